/* common/dll_cfg_pkg.sv */
// config register map, field positions, divider select encoding, lock counter thresholds
package dll_cfg_pkg;

   // ----------------------------------------------------------------------
   // register map
   // ----------------------------------------------------------------------
   localparam int unsigned CFG_ADDR_WIDTH = 2;
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_CTRL   = 2'd0;  // clkdiv, selflock, scan
   localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_ENABLE = 2'd1;  // search enable

   // control register fields
   localparam int unsigned CLKDIV_WIDTH      = 3;
   localparam int unsigned CTRL_CLKDIV_LSB   = 0;  // [2:0]
   localparam int unsigned CTRL_SELFLOCK_BIT = 3;
   localparam int unsigned CTRL_SCAN_N_BIT   = 4;  // low = bypass divider
   localparam int unsigned ENABLE_SEARCH_BIT = 0;

   // ----------------------------------------------------------------------
   // divider select, value n gives clk / 2**(n+3)
   // ----------------------------------------------------------------------
   typedef enum logic [CLKDIV_WIDTH-1:0] {
      CLKDIV_8    = 3'd0,
      CLKDIV_16   = 3'd1,
      CLKDIV_32   = 3'd2,
      CLKDIV_64   = 3'd3,
      CLKDIV_128  = 3'd4,
      CLKDIV_256  = 3'd5,
      CLKDIV_512  = 3'd6,
      CLKDIV_1024 = 3'd7
   } clkdiv_t;

   localparam int unsigned DIV_CNT_WIDTH     = 10;  // free-running ref divider
   localparam int unsigned CLKDIV_TAP_OFFSET = 2;   // select n -> divider bit n+2

   // self-timed lock counter
   localparam int unsigned LOCK_CNT_WIDTH = 8;
   localparam logic [LOCK_CNT_WIDTH-1:0] PRELOCK_COUNT  = 8'd150;
   localparam logic [LOCK_CNT_WIDTH-1:0] SELFLOCK_COUNT = 8'd255;

endpackage

/* common/dll_ctrl_pkg.sv */
// delay-code defaults, search FSM state type, update interval constants
package dll_ctrl_pkg;

   // ----------------------------------------------------------------------
   // delay code
   // ----------------------------------------------------------------------
   localparam int unsigned DEFAULT_CODE_WIDTH = 8;  // top level default only

   // search / track FSM
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,  // waiting for prelock and enable
      ST_SEARCH = 2'd1,  // binary search, one bit per update
      ST_TRACK  = 2'd2   // +/- one step per update
   } search_state_t;

   // ----------------------------------------------------------------------
   // update pacing
   // ----------------------------------------------------------------------
   // clk cycles between phase samples, lets the delay line settle
   localparam int unsigned UPDATE_INTERVAL = 16;
   localparam int unsigned INTERVAL_WIDTH  = $clog2(UPDATE_INTERVAL);

endpackage

/* common/dll_cfg_if.sv */
// static configuration bundle from register block to lock and control blocks
`timescale 1ns/1ps

interface dll_cfg_if;
   import dll_cfg_pkg::*;

   clkdiv_t clkdiv;       // divided clock select
   logic    selflock;     // 1 = self-timed lock, 0 = fsm lock monitor
   logic    scan_mode_n;  // low = divider bypassed to clk
   logic    search_en;    // allow binary search after prelock

   // register block owns every field
   modport regs (
      output clkdiv,
      output selflock,
      output scan_mode_n,
      output search_en
   );

   // self-timed lock block
   modport lock (
      input clkdiv,
      input selflock,
      input scan_mode_n
   );

   // code search
   modport ctrl (
      input search_en
   );

endinterface

/* self_lock/lock_bit_sync.sv */
// two-flop bit synchronizer, clears to zero on reset
`timescale 1ns/1ps

module lock_bit_sync (
   input  logic clk,       // destination clock
   input  logic reset_n,
   input  logic data_in,   // from another clock domain
   output logic data_out
);

   logic meta;  // first stage, may go metastable

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         meta     <= 1'b0;
         data_out <= 1'b0;
      end else begin
         meta     <= data_in;
         data_out <= meta;  // 2 cycle latency
      end
   end

endmodule

/* self_lock/self_lock_assertion.sv */
// self-timed lock: ref divider, divided clock select, lock counter, lock select, sync
`timescale 1ns/1ps

module self_lock_assertion (
   input  logic    clk,       // reference clock
   input  logic    reset_n,
   dll_cfg_if.lock cfg,
   input  logic    fsm_lock,  // from lock monitor
   output logic    prelock,   // starts binary search
   output logic    lock       // to core
);
   import dll_cfg_pkg::*;

   localparam int unsigned TAP_SEL_WIDTH = $clog2(DIV_CNT_WIDTH);

   logic [DIV_CNT_WIDTH-1:0]  count1024;  // free-running divider
   logic [TAP_SEL_WIDTH-1:0]  tap_sel;
   logic                      tap_clk;
   logic                      div_clk;
   logic                      div_running;  // first divided edge is near
   logic [LOCK_CNT_WIDTH-1:0] cntr256;
   logic                      pre_lock;
   logic                      self_lock_presync;
   logic                      lock_presync;

   // ----------------------------------------------------------------------
   // reference divider and divided clock select
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         count1024   <= '0;
         div_running <= 1'b0;
      end else begin
         count1024   <= count1024 + 1'b1;  // wraps at 1024
         div_running <= div_running | count1024[tap_sel];  // sticky
      end
   end

   assign tap_sel = TAP_SEL_WIDTH'(cfg.clkdiv) + TAP_SEL_WIDTH'(CLKDIV_TAP_OFFSET);
   // inverted tap, so each rising edge closes a whole period after reset
   assign tap_clk = ~count1024[tap_sel];
   assign div_clk = cfg.scan_mode_n ? tap_clk : clk;  // scan bypass

   // ----------------------------------------------------------------------
   // self-timed counter on the divided clock
   // prelock on edge 151, self lock on edge 256, both sticky
   // ----------------------------------------------------------------------
   always_ff @(posedge div_clk or negedge reset_n) begin
      if (!reset_n) begin
         cntr256           <= '0;
         pre_lock          <= 1'b0;
         self_lock_presync <= 1'b0;
      end else if (cntr256 < PRELOCK_COUNT) begin
         cntr256 <= cntr256 + 1'b1;
      end else if (cntr256 < SELFLOCK_COUNT) begin
         pre_lock <= 1'b1;
         cntr256  <= cntr256 + 1'b1;
      end else begin
         self_lock_presync <= 1'b1;  // counter parks at 255
      end
   end

   // lock source select, register bit
   assign lock_presync = cfg.selflock ? self_lock_presync : fsm_lock;

   // back to clk
   lock_bit_sync i_prelock_sync (
      .clk      (clk),
      .reset_n  (reset_n),
      .data_in  (pre_lock),
      .data_out (prelock)
   );

   lock_bit_sync i_lock_sync (
      .clk      (clk),
      .reset_n  (reset_n),
      .data_in  (lock_presync),
      .data_out (lock)
   );

   // self-timed lock must come after prelock through the same sync path
   a_lock_after_prelock: assert property (@(posedge clk) disable iff (!reset_n)
      (cfg.selflock && $rose(lock)) |-> prelock);

   // divider select is static once the selected tap has started toggling
   a_clkdiv_static: assert property (@(posedge clk) disable iff (!reset_n)
      (cfg.scan_mode_n && $changed(cfg.clkdiv)) |-> !div_running);

endmodule

/* design/dll_cfg_regs.sv */
// config register block: write decode and storage of the DLL control fields
`timescale 1ns/1ps

module dll_cfg_regs (
   input  logic                                clk,
   input  logic                                reset_n,
   input  logic                                cfg_wr,
   input  logic [dll_cfg_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
   input  logic [7:0]                          cfg_wdata,
   dll_cfg_if.regs                             cfg
);
   import dll_cfg_pkg::*;

   logic wr_ctrl;    // write hits control reg
   logic wr_enable;  // write hits search enable reg

   // ----------------------------------------------------------------------
   // address decode
   // ----------------------------------------------------------------------
   assign wr_ctrl   = cfg_wr && (cfg_addr == CFG_ADDR_CTRL);
   assign wr_enable = cfg_wr && (cfg_addr == CFG_ADDR_ENABLE);

   // ----------------------------------------------------------------------
   // control register
   // defaults give the self-timed path, div8, divider active
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         cfg.clkdiv      <= CLKDIV_8;
         cfg.selflock    <= 1'b1;
         cfg.scan_mode_n <= 1'b1;
      end else if (wr_ctrl) begin
         cfg.clkdiv      <= clkdiv_t'(cfg_wdata[CTRL_CLKDIV_LSB +: CLKDIV_WIDTH]);
         cfg.selflock    <= cfg_wdata[CTRL_SELFLOCK_BIT];
         cfg.scan_mode_n <= cfg_wdata[CTRL_SCAN_N_BIT];
      end
   end

   // search enable, off until software asks
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         cfg.search_en <= 1'b0;
      end else if (wr_enable) begin
         cfg.search_en <= cfg_wdata[ENABLE_SEARCH_BIT];
      end
   end

   // unmapped addresses are dropped silently, no read path

endmodule

/* dll_ctrl/dll_code_search.sv */
// delay code update tick, binary search and one-step tracking
`timescale 1ns/1ps

module dll_code_search #(
   parameter int unsigned CODE_WIDTH = dll_ctrl_pkg::DEFAULT_CODE_WIDTH
) (
   input  logic                  clk,
   input  logic                  reset_n,
   dll_cfg_if.ctrl               cfg,
   input  logic                  start,        // synchronized prelock
   input  logic                  phase_late,   // high = line too short
   output logic [CODE_WIDTH-1:0] delay_code,
   output logic                  code_update,  // one cycle per code step
   output logic                  tracking      // last step was a tracking step
);
   import dll_ctrl_pkg::*;

   localparam logic [CODE_WIDTH-1:0] HALF_CODE = CODE_WIDTH'(1) << (CODE_WIDTH - 1);

   search_state_t             state;
   logic [INTERVAL_WIDTH-1:0] interval_cnt;
   logic                      tick;       // phase sample point
   logic [CODE_WIDTH-1:0]     trial;      // one-hot bit under test
   logic                      sar_go;     // search step this tick
   logic [CODE_WIDTH-1:0]     sar_code;
   logic [CODE_WIDTH-1:0]     track_code;

   // ----------------------------------------------------------------------
   // update interval
   // ----------------------------------------------------------------------
   assign tick = (interval_cnt == INTERVAL_WIDTH'(UPDATE_INTERVAL - 1));

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         interval_cnt <= '0;
      end else begin
         interval_cnt <= tick ? '0 : interval_cnt + 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // next code candidates
   // ----------------------------------------------------------------------
   // keep trial bit if still late, then try the next lower bit
   assign sar_code = (phase_late ? delay_code : (delay_code & ~trial)) | (trial >> 1);

   // one saturating step toward the edge
   assign track_code = phase_late ? ((&delay_code) ? delay_code : delay_code + 1'b1)
                                  : ((~|delay_code) ? delay_code : delay_code - 1'b1);

   // first search step lands on the first tick with prelock and enable
   assign sar_go = (state == ST_SEARCH) ||
                   ((state == ST_IDLE) && start && cfg.search_en);

   // ----------------------------------------------------------------------
   // search / track FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state       <= ST_IDLE;
         delay_code  <= HALF_CODE;  // mid scale until search
         trial       <= HALF_CODE;  // msb first
         code_update <= 1'b0;
         tracking    <= 1'b0;
      end else begin
         code_update <= 1'b0;
         if (tick && sar_go) begin
            delay_code  <= sar_code;
            trial       <= trial >> 1;
            code_update <= 1'b1;
            tracking    <= 1'b0;
            state       <= trial[0] ? ST_TRACK : ST_SEARCH;  // lsb decided -> done
         end else if (tick && (state == ST_TRACK)) begin
            delay_code  <= track_code;
            code_update <= 1'b1;
            tracking    <= 1'b1;
         end
      end
   end

   // in track the code moves only on an update and by one step at most
   a_track_one_step: assert property (@(posedge clk) disable iff (!reset_n)
      (state == ST_TRACK) |=>
         (code_update ? ((delay_code == $past(delay_code)) ||
                         (delay_code == $past(delay_code) + CODE_WIDTH'(1)) ||
                         ($past(delay_code) == delay_code + CODE_WIDTH'(1)))
                      : $stable(delay_code)));

endmodule

/* dll_ctrl/dll_lock_monitor.sv */
// lock monitor: counts stable tracking updates, raises fsm_lock
`timescale 1ns/1ps

module dll_lock_monitor #(
   parameter int unsigned CODE_WIDTH   = dll_ctrl_pkg::DEFAULT_CODE_WIDTH,
   parameter int unsigned LOCK_UPDATES = 8
) (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic [CODE_WIDTH-1:0] delay_code,
   input  logic                  code_update,  // new code this cycle
   input  logic                  tracking,     // update came from tracking
   output logic                  fsm_lock
);

   localparam int unsigned CNT_WIDTH = $clog2(LOCK_UPDATES + 1);

   logic [CODE_WIDTH-1:0] prev_code;   // code before this update
   logic [CNT_WIDTH-1:0]  stable_cnt;  // consecutive small steps
   logic                  small_step;  // moved by 0 or 1

   assign small_step = (delay_code == prev_code) ||
                       (delay_code == prev_code + 1'b1) ||
                       (prev_code == delay_code + 1'b1);

   // previous code, refreshed on every update, search steps too
   always_ff @(posedge clk) begin
      if (code_update) begin
         prev_code <= delay_code;
      end
   end

   // ----------------------------------------------------------------------
   // stability count, saturates at LOCK_UPDATES
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         stable_cnt <= '0;
         fsm_lock   <= 1'b0;
      end else if (code_update) begin
         if (!tracking || !small_step) begin
            stable_cnt <= '0;  // search step or jump, start over
            fsm_lock   <= 1'b0;
         end else if (stable_cnt < CNT_WIDTH'(LOCK_UPDATES)) begin
            stable_cnt <= stable_cnt + 1'b1;
            fsm_lock   <= (stable_cnt == CNT_WIDTH'(LOCK_UPDATES - 1));
         end
      end
   end

endmodule

/* design/dll_lock_top.sv */
// DLL lock subsystem top: config regs, self-timed lock, code search, lock monitor
`timescale 1ns/1ps

module dll_lock_top #(
   parameter int unsigned CODE_WIDTH   = dll_ctrl_pkg::DEFAULT_CODE_WIDTH,
   parameter int unsigned LOCK_UPDATES = 8
) (
   input  logic                                   clk,
   input  logic                                   reset_n,
   // register write port
   input  logic                                   cfg_wr,
   input  logic [dll_cfg_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
   input  logic [7:0]                             cfg_wdata,
   // phase detector
   input  logic                                   phase_late,
   // to delay line and core
   output logic [CODE_WIDTH-1:0]                  delay_code,
   output logic                                   prelock,
   output logic                                   lock
);

   logic fsm_lock;     // monitor -> lock select
   logic code_update;  // search -> monitor
   logic tracking;     // search -> monitor

   dll_cfg_if i_cfg_if ();

   // ----------------------------------------------------------------------
   // configuration
   // ----------------------------------------------------------------------
   dll_cfg_regs i_dll_cfg_regs (
      .clk       (clk),
      .reset_n   (reset_n),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (i_cfg_if.regs)
   );

   // ----------------------------------------------------------------------
   // self-timed lock and lock select
   // ----------------------------------------------------------------------
   self_lock_assertion i_self_lock_assertion (
      .clk      (clk),
      .reset_n  (reset_n),
      .cfg      (i_cfg_if.lock),
      .fsm_lock (fsm_lock),
      .prelock  (prelock),
      .lock     (lock)
   );

   // ----------------------------------------------------------------------
   // delay code control, started by the synchronized prelock
   // ----------------------------------------------------------------------
   dll_code_search #(
      .CODE_WIDTH (CODE_WIDTH)
   ) i_dll_code_search (
      .clk         (clk),
      .reset_n     (reset_n),
      .cfg         (i_cfg_if.ctrl),
      .start       (prelock),
      .phase_late  (phase_late),
      .delay_code  (delay_code),
      .code_update (code_update),
      .tracking    (tracking)
   );

   dll_lock_monitor #(
      .CODE_WIDTH   (CODE_WIDTH),
      .LOCK_UPDATES (LOCK_UPDATES)
   ) i_dll_lock_monitor (
      .clk         (clk),
      .reset_n     (reset_n),
      .delay_code  (delay_code),
      .code_update (code_update),
      .tracking    (tracking),
      .fsm_lock    (fsm_lock)
   );

endmodule

/* testbench/tb_dll_lock.sv */
// testbench for the DLL lock subsystem: clock, reset, phase model, reference, checks, watchdog
`timescale 1ns/1ps

module tb_dll_lock;
   import dll_cfg_pkg::*;

   localparam int CODE_WIDTH      = 8;
   localparam int LOCK_UPDATES    = 8;
   localparam int UI              = dll_ctrl_pkg::UPDATE_INTERVAL;  // clk cycles per update
   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 8;
   localparam int PRELOCK_EDGES   = 151;  // divided edges to prelock
   localparam int SELFLOCK_EDGES  = 255;
   localparam int SYNC_SLACK      = 3;    // edge phase plus two sync flops
   localparam int HALF_CODE       = 1 << (CODE_WIDTH - 1);
   localparam int RUN_COUNT       = 8;    // reset scenarios below
   localparam int WATCHDOG_CYCLES =
      RUN_COUNT * (256 * 1024 + 100 + RESET_CYCLES + (CODE_WIDTH + LOCK_UPDATES + 8) * UI);
   localparam logic [31:0] SEED   = 32'h051f_5491;

   logic                      clk;
   logic                      reset_n;
   logic                      cfg_wr;
   logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
   logic [7:0]                cfg_wdata;
   logic                      phase_late = 1'b0;
   logic [CODE_WIDTH-1:0]     delay_code;
   logic                      prelock;
   logic                      lock;

   int cyc;               // clk cycles since reset release
   int prelock_rise;      // first cycle seen high, -1 = not yet
   int lock_rise;
   int target_code = 0;   // phase detector model target
   bit check_track;       // code must dither around target
   bit check_idle;        // code parked, lock low
   int check_count;
   int error_count;

   dll_lock_top #(
      .CODE_WIDTH   (CODE_WIDTH),
      .LOCK_UPDATES (LOCK_UPDATES)
   ) i_dll_lock_top (
      .clk        (clk),
      .reset_n    (reset_n),
      .cfg_wr     (cfg_wr),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .phase_late (phase_late),
      .delay_code (delay_code),
      .prelock    (prelock),
      .lock       (lock)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   // ----------------------------------------------------------------------
   // phase detector model and reference functions
   // ----------------------------------------------------------------------
   // late = line too short, code below target
   function automatic bit model_late(input int code, input int target);
      return code < target;
   endfunction

   always @(negedge clk) phase_late <= model_late(int'(delay_code), target_code);

   // largest code the model still calls late, 0 if none
   function automatic int search_ref(input int target);
      int c;
      int best;
      best = 0;
      for (c = 0; c < (1 << CODE_WIDTH); c++) begin
         if (model_late(c, target)) best = c;
      end
      return best;
   endfunction

   // rise window in clk cycles after reset release, P = 1 in scan mode
   function automatic void lock_window(input int clkdiv, input bit scan_n, input int edges,
                                       output int lo, output int hi);
      int period;
      period = scan_n ? (1 << (clkdiv + 3)) : 1;
      lo = edges * period;
      hi = (edges + 1) * period + SYNC_SLACK;
   endfunction

   function automatic int code_distance(input int a, input int b);
      return (a > b) ? a - b : b - a;
   endfunction

   // ----------------------------------------------------------------------
   // check and report
   // ----------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("failure at %0t: %s", $time, what);
   endtask

   task automatic check_window(input string name, input int rise, input int lo, input int hi);
      check_count++;
      if (rise < 0) begin
         report_failure($sformatf("%s never rose, window %0d..%0d", name, lo, hi));
      end else if ((rise < lo) || (rise > hi)) begin
         report_failure($sformatf("%s rose at cycle %0d, outside %0d..%0d", name, rise, lo, hi));
      end
   endtask

   // outputs sampled mid cycle, away from the rising edge
   always @(negedge clk) begin
      if (reset_n) begin
         if (prelock && (prelock_rise < 0)) prelock_rise = cyc;
         if (lock && (lock_rise < 0)) lock_rise = cyc;
         if (check_track && (code_distance(int'(delay_code), target_code) > 1)) begin
            report_failure($sformatf("delay_code %0d more than one step from target %0d",
                                     delay_code, target_code));
         end
         if (check_idle) begin
            check_value("delay_code", 32'(delay_code), HALF_CODE);
            check_value("lock", 32'(lock), 0);
         end
      end
   end

   // ----------------------------------------------------------------------
   // sequencing helpers
   // ----------------------------------------------------------------------
   task automatic wait_until_cycle(input int n);
      do @(negedge clk); while (cyc < n);
   endtask

   // rise records are written at negedge, read them at posedge
   task automatic wait_rise(input bit of_lock, input int limit);
      @(posedge clk);
      while ((((of_lock) ? lock_rise : prelock_rise) < 0) && (cyc <= limit)) @(posedge clk);
   endtask

   // reset, then control and enable writes right at release
   task automatic start_run(input logic [2:0] clkdiv, input logic selflock,
                            input logic scan_n, input logic search);
      @(posedge clk);
      check_track  = 1'b0;
      check_idle   = 1'b0;
      prelock_rise = -1;
      lock_rise    = -1;
      @(negedge clk);
      reset_n = 1'b0;
      cfg_wr  = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset_n   = 1'b1;
      cfg_wr    = 1'b1;
      cfg_addr  = CFG_ADDR_CTRL;
      cfg_wdata = {3'b000, scan_n, selflock, clkdiv};
      @(negedge clk);
      cfg_addr  = CFG_ADDR_ENABLE;
      cfg_wdata = {7'd0, search};
      @(negedge clk);
      cfg_wr = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // scenarios
   // ----------------------------------------------------------------------
   task automatic run_self_lock(input int clkdiv, input bit scan_n);
      int pre_lo;
      int pre_hi;
      int lock_lo;
      int lock_hi;
      lock_window(clkdiv, scan_n, PRELOCK_EDGES, pre_lo, pre_hi);
      lock_window(clkdiv, scan_n, SELFLOCK_EDGES, lock_lo, lock_hi);
      start_run(3'(clkdiv), 1'b1, scan_n, 1'b0);
      wait_rise(1'b1, lock_hi + UI);
      check_window("prelock", prelock_rise, pre_lo, pre_hi);
      check_window("lock", lock_rise, lock_lo, lock_hi);
      @(negedge clk);
      check_value("prelock", 32'(prelock), 1);  // sticky
      check_value("lock", 32'(lock), 1);
   endtask

   // search result, then dithering and fsm lock timing
   task automatic run_search(input int target);
      int r;
      int pre_lo;
      int pre_hi;
      int lock_lo;
      int lock_hi;
      lock_window(0, 1'b0, PRELOCK_EDGES, pre_lo, pre_hi);
      @(posedge clk);
      target_code = target;
      start_run(3'd0, 1'b0, 1'b0, 1'b1);  // scan mode, fsm lock source
      wait_rise(1'b0, pre_hi + UI);
      check_window("prelock", prelock_rise, pre_lo, pre_hi);
      if (prelock_rise >= 0) begin
         r = prelock_rise;
         lock_lo = r + (CODE_WIDTH + LOCK_UPDATES - 1) * UI;
         lock_hi = r + (CODE_WIDTH + LOCK_UPDATES) * UI + SYNC_SLACK;
         wait_until_cycle(r + CODE_WIDTH * UI);
         check_value("delay_code", 32'(delay_code), search_ref(target));
         @(posedge clk);
         check_track = 1'b1;
         wait_rise(1'b1, lock_hi + UI);
         check_window("lock", lock_rise, lock_lo, lock_hi);
         wait_until_cycle(lock_hi + 4 * UI);
         check_value("lock", 32'(lock), 1);  // holds while dithering
         @(posedge clk);
         check_track = 1'b0;
      end
   endtask

   // fsm lock source with search off, self-timed window passes unseen
   task automatic run_no_search();
      int lock_lo;
      int lock_hi;
      lock_window(0, 1'b1, SELFLOCK_EDGES, lock_lo, lock_hi);
      start_run(3'd0, 1'b0, 1'b1, 1'b0);
      @(posedge clk);
      check_idle = 1'b1;
      wait_until_cycle(lock_hi + 4 * UI);
      check_value("prelock", 32'(prelock), 1);
      @(posedge clk);
      check_idle = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // watchdog and main sequence
   // ----------------------------------------------------------------------
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      reset_n      = 1'b0;
      cfg_wr       = 1'b0;
      cfg_addr     = '0;
      cfg_wdata    = '0;
      prelock_rise = -1;
      lock_rise    = -1;
      check_count  = 0;
      error_count  = 0;
      void'($urandom(SEED));
      run_self_lock(0, 1'b1);
      run_self_lock(3, 1'b1);
      run_self_lock(7, 1'b1);
      run_self_lock(0, 1'b0);  // scan bypass
      repeat (3) run_search(int'($urandom % (1 << CODE_WIDTH)));
      run_no_search();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* files.f */
common/dll_cfg_pkg.sv
common/dll_ctrl_pkg.sv
common/dll_cfg_if.sv
self_lock/lock_bit_sync.sv
self_lock/self_lock_assertion.sv
design/dll_cfg_regs.sv
dll_ctrl/dll_code_search.sv
dll_ctrl/dll_lock_monitor.sv
design/dll_lock_top.sv
testbench/tb_dll_lock.sv

/* Makefile */
# Verilator build and run of the DLL lock testbench
TOP := tb_dll_lock
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

# an abnormal exit counts as a failure in the log
run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Test FAILED" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Test FAILED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
